/* vlog.f */
+incdir+logic
logic/rob_pkg.sv
logic/dispatch_decoder.sv
logic/reorder_buffer.sv
logic/commit_unit.sv
logic/rob_top.sv
testbench/rob_props.sv
testbench/rob_tb.sv

/* testbench/rob_tb.sv */
`timescale 1ns/100ps
`include "rob_defines.svh"

module rob_tb;

    import rob_pkg::*;

    localparam int      CLK_PERIOD = 20;
    localparam int      NUM_ROWS   = 24;
    localparam int      MAX_CYCLES = NUM_ROWS * 40 + 200;
    localparam int      K_ALU      = 0;
    localparam int      K_STORE    = 1;
    localparam int      K_BRANCH   = 2;
    localparam opcode_t OP_ALU     = 7'b0110011;

    // slot gives the completion position of a row within its batch
    typedef struct packed {
        logic [1:0] kind;
        reg_idx_t   rd;
        logic       pred;
        logic       act;
        xdata_t     data;
        pc_t        target;
        logic [4:0] slot;
    } row_t;

    logic           clk;
    logic           arst_n;
    logic           issue_valid;
    issue_t         issue;
    logic           complete_valid;
    complete_t      complete;
    logic           tag_valid;
    tag_t           tag_out;
    logic           full;
    logic           retire_valid;
    retire_report_t retire;
    logic           store_valid;
    tag_t           store_tag;
    logic           redirect_valid;
    pc_t            redirect_pc;
    reg_idx_t       rf_read_addr;
    xdata_t         rf_read_data;

    row_t        rows [NUM_ROWS];
    tag_t        row_tag [NUM_ROWS];
    int          exp_q [$];
    xdata_t      rf_model [32];
    tag_t        next_tag;
    logic [31:0] rng;
    string       test_name;

    rob_top DUT (.*);

    bind rob_top rob_props u_props (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(string why);
        $display("[ERROR] %s: %s", test_name, why);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_error(string what, logic [63:0] exp_val, logic [63:0] act_val);
        $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp_val, act_val);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic row_t make_row(int kind, int rd, int pred, int act, xdata_t data,
                                      pc_t target, int slot);
        row_t r;
        r.kind   = kind[1:0];
        r.rd     = rd[4:0];
        r.pred   = pred[0];
        r.act    = act[0];
        r.data   = data;
        r.target = target;
        r.slot   = slot[4:0];
        return r;
    endfunction

    function automatic opcode_t opcode_of(logic [1:0] kind);
        return (kind == K_STORE) ? `OP_STORE : (kind == K_BRANCH) ? `OP_BRANCH : OP_ALU;
    endfunction

    // only plain ops with a nonzero rd write the register file
    function automatic logic writes_rd_of(row_t r);
        return (r.kind == K_ALU) && (r.rd != '0);
    endfunction

    task automatic load_table();
        // batch 0 covers rows 0..3
        rows[0]  = make_row(K_ALU,    1,  0, 0, 32'h1111_0001, 32'h0,         2);
        rows[1]  = make_row(K_STORE,  7,  0, 0, 32'h5700_0001, 32'h0,         0);
        rows[2]  = make_row(K_BRANCH, 0,  1, 1, 32'h0,         32'h8000_0100, 3);
        rows[3]  = make_row(K_ALU,    0,  0, 0, 32'hdead_beef, 32'h0,         1);
        // batch 1 (rows 4..19) wraps the tags and fills the buffer
        rows[4]  = make_row(K_ALU,    2,  0, 0, 32'h2222_0002, 32'h0,         5);
        rows[5]  = make_row(K_ALU,    3,  0, 0, 32'h3333_0003, 32'h0,         11);
        rows[6]  = make_row(K_STORE,  5,  0, 0, 32'h5700_0006, 32'h0,         0);
        rows[7]  = make_row(K_ALU,    1,  0, 0, 32'h1111_0007, 32'h0,         14);
        rows[8]  = make_row(K_BRANCH, 0,  0, 0, 32'h0,         32'h8000_0200, 2);
        rows[9]  = make_row(K_ALU,    4,  0, 0, 32'h4444_0009, 32'h0,         9);
        rows[10] = make_row(K_STORE,  0,  0, 0, 32'h5700_000a, 32'h0,         7);
        rows[11] = make_row(K_ALU,    6,  0, 0, 32'h6666_000b, 32'h0,         15);
        rows[12] = make_row(K_ALU,    7,  0, 0, 32'h7777_000c, 32'h0,         1);
        rows[13] = make_row(K_BRANCH, 0,  0, 1, 32'h0,         32'h8000_0240, 12);
        rows[14] = make_row(K_ALU,    8,  0, 0, 32'h8888_000e, 32'h0,         4);
        rows[15] = make_row(K_ALU,    9,  0, 0, 32'h9999_000f, 32'h0,         13);
        rows[16] = make_row(K_STORE,  4,  0, 0, 32'h5700_0010, 32'h0,         3);
        rows[17] = make_row(K_ALU,    10, 0, 0, 32'haaaa_0011, 32'h0,         10);
        rows[18] = make_row(K_ALU,    2,  0, 0, 32'hbad0_0012, 32'h0,         6);
        rows[19] = make_row(K_BRANCH, 0,  1, 0, 32'h0,         32'h8000_0280, 8);
        // batch 2 (rows 20..23) starts again from tag 0 after the flush
        rows[20] = make_row(K_ALU,    11, 0, 0, 32'hbbbb_0014, 32'h0,         1);
        rows[21] = make_row(K_STORE,  3,  0, 0, 32'h5700_0015, 32'h0,         3);
        rows[22] = make_row(K_ALU,    3,  0, 0, 32'h3333_0016, 32'h0,         0);
        rows[23] = make_row(K_BRANCH, 0,  1, 0, 32'h0,         32'h8000_0400, 2);
    endtask

    // retirement checker against the in-order model
    always @(posedge clk) begin
        int   idx;
        row_t r;
        logic mispredict;
        #2;
        if (arst_n && retire_valid) begin
            assert (exp_q.size() > 0) else abort_run("retirement with nothing outstanding");
            idx = exp_q.pop_front();
            r = rows[idx];
            mispredict = (r.kind == K_BRANCH) && (r.pred != r.act);
            assert (retire.tag == row_tag[idx])
                else value_error("retire tag", row_tag[idx], retire.tag);
            assert (retire.rd == r.rd) else value_error("retire rd", r.rd, retire.rd);
            assert (retire.data == r.data) else value_error("retire data", r.data, retire.data);
            assert (retire.wrote_rd == writes_rd_of(r))
                else value_error("wrote_rd", writes_rd_of(r), retire.wrote_rd);
            assert (retire.was_store == (r.kind == K_STORE))
                else value_error("was_store", r.kind == K_STORE, retire.was_store);
            assert (store_valid == (r.kind == K_STORE))
                else value_error("store_valid", r.kind == K_STORE, store_valid);
            if (r.kind == K_STORE) begin
                assert (store_tag == row_tag[idx])
                    else value_error("store_tag", row_tag[idx], store_tag);
            end
            assert (redirect_valid == mispredict)
                else value_error("redirect_valid", mispredict, redirect_valid);
            if (mispredict) begin
                assert (redirect_pc == r.target)
                    else value_error("redirect_pc", r.target, redirect_pc);
                // younger entries were flushed
                exp_q.delete();
                next_tag = '0;
            end
            if (writes_rd_of(r)) begin
                rf_model[r.rd] = r.data;
            end
            assert (full == (exp_q.size() >= `ROB_DEPTH))
                else value_error("full after retire", exp_q.size() >= `ROB_DEPTH, full);
            rf_read_addr = r.rd;
            #1;
            assert (rf_read_data == rf_model[r.rd])
                else value_error("register file", rf_model[r.rd], rf_read_data);
        end
    end

    always @(posedge clk) begin
        #3;
        assert (DUT.u_props.failures == 0)
            else abort_run("a bound protocol property failed");
    end

    task automatic wait_drain(int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        assert (exp_q.size() == 0) else abort_run("instructions did not retire in time");
        // room for any stray late retirement
        repeat (4) @(posedge clk);
    endtask

    task automatic run_batch(string name, int first, int count);
        int order [`ROB_DEPTH];
        int j;
        int tmp;
        test_name = name;
        for (int i = first; i < first + count; i++) begin
            @(posedge clk);
            #2;
            issue_valid = 1'b1;
            issue = {opcode_of(rows[i].kind), rows[i].rd, rows[i].pred};
            @(posedge clk);
            #2;
            issue_valid = 1'b0;
            assert (tag_valid) else abort_run("no tag_valid in the cycle after an issue");
            assert (tag_out == next_tag) else value_error("tag", next_tag, tag_out);
            row_tag[i] = tag_out;
            exp_q.push_back(i);
            next_tag = next_tag + 1'b1;
        end
        @(posedge clk);
        #2;
        assert (full == (exp_q.size() == `ROB_DEPTH))
            else value_error("full after issue", exp_q.size() == `ROB_DEPTH, full);
        for (int i = first; i < first + count; i++) begin
            order[rows[i].slot] = i;
        end
        // shuffle the table order
        for (int k = count - 1; k > 0; k--) begin
            rng = xorshift32(rng);
            j = rng % (k + 1);
            tmp = order[k];
            order[k] = order[j];
            order[j] = tmp;
        end
        for (int k = 0; k < count; k++) begin
            @(posedge clk);
            #2;
            complete_valid = 1'b1;
            complete = {row_tag[order[k]], rows[order[k]].data, rows[order[k]].act,
                        rows[order[k]].target};
        end
        @(posedge clk);
        #2;
        complete_valid = 1'b0;
        wait_drain(count * 8);
    endtask

    task automatic check_regfile();
        test_name = "regfile_final";
        for (int a = 0; a < 32; a++) begin
            rf_read_addr = a[4:0];
            #1;
            assert (rf_read_data == rf_model[a])
                else value_error($sformatf("x%0d", a), rf_model[a], rf_read_data);
        end
    endtask

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("[ERROR] watchdog: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    initial begin
        arst_n = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        complete_valid = 1'b0;
        complete = '0;
        rf_read_addr = '0;
        next_tag = '0;
        rng = 32'd33;
        test_name = "reset";
        foreach (rf_model[i]) begin
            rf_model[i] = '0;
        end
        load_table();
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        run_batch("in_order_retire", 0, 4);
        run_batch("wrap_full_mispredict", 4, 16);
        run_batch("tag_after_flush", 20, 4);
        check_regfile();
        if (DUT.u_props.failures == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "property checks failed");
        end
    end

endmodule

/* testbench/rob_props.sv */
`timescale 1ns/100ps

module rob_props (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    issue_valid,
    input logic                    full,
    input logic                    flush,
    input logic                    tag_valid,
    input logic                    retire_valid,
    input rob_pkg::retire_report_t retire,
    input logic                    store_valid,
    input rob_pkg::tag_t           store_tag,
    input logic                    redirect_valid
);

    int failures = 0;

    // the outside must never issue into a full buffer
    no_issue_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        !(issue_valid && full))
        else begin
            failures++;
            $error("issue strobe while the buffer is full");
        end

    // a store release always matches the retirement reported with it
    store_matches_retire: assert property (@(posedge clk) disable iff (!arst_n)
        store_valid |-> (retire_valid && retire.was_store && (store_tag == retire.tag)))
        else begin
            failures++;
            $error("store release without a matching store retirement");
        end

    redirect_with_retire: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |-> (retire_valid && !store_valid))
        else begin
            failures++;
            $error("redirect without a branch retirement");
        end

    flush_then_redirect: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> redirect_valid)
        else begin
            failures++;
            $error("flush not followed by a redirect");
        end

    // dispatch stage is emptied by the flush
    no_tag_after_flush: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !tag_valid)
        else begin
            failures++;
            $error("tag handed out in the cycle after a flush");
        end

endmodule

/* logic/rob_top.sv */
`timescale 1ns/100ps

module rob_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     issue_valid,
    input  rob_pkg::issue_t          issue,
    input  logic                     complete_valid,
    input  rob_pkg::complete_t       complete,
    output logic                     tag_valid,
    output rob_pkg::tag_t            tag_out,
    output logic                     full,
    output logic                     retire_valid,
    output rob_pkg::retire_report_t  retire,
    output logic                     store_valid,
    output rob_pkg::tag_t            store_tag,
    output logic                     redirect_valid,
    output rob_pkg::pc_t             redirect_pc,
    input  rob_pkg::reg_idx_t        rf_read_addr,
    output rob_pkg::xdata_t          rf_read_data
);

    import rob_pkg::*;

    logic      disp_valid;
    dispatch_t disp;
    logic      head_valid;
    retire_t   head;
    // mispredict flush, fans out to decoder and buffer
    logic      flush;

    dispatch_decoder u_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .flush       (flush),
        .disp_valid  (disp_valid),
        .disp        (disp)
    );

    reorder_buffer u_rob (
        .clk            (clk),
        .arst_n         (arst_n),
        .disp_valid     (disp_valid),
        .disp           (disp),
        .complete_valid (complete_valid),
        .complete       (complete),
        .flush          (flush),
        .tag_valid      (tag_valid),
        .tag_out        (tag_out),
        .full           (full),
        .head_valid     (head_valid),
        .head           (head)
    );

    commit_unit u_commit (
        .clk            (clk),
        .arst_n         (arst_n),
        .head_valid     (head_valid),
        .head           (head),
        .flush          (flush),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .store_valid    (store_valid),
        .store_tag      (store_tag),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .rf_read_addr   (rf_read_addr),
        .rf_read_data   (rf_read_data)
    );

endmodule

/* logic/commit_unit.sv */
`timescale 1ns/100ps
`include "rob_defines.svh"

module commit_unit (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     head_valid,
    input  rob_pkg::retire_t         head,
    output logic                     flush,
    output logic                     retire_valid,
    output rob_pkg::retire_report_t  retire,
    output logic                     store_valid,
    output rob_pkg::tag_t            store_tag,
    output logic                     redirect_valid,
    output rob_pkg::pc_t             redirect_pc,
    input  rob_pkg::reg_idx_t        rf_read_addr,
    output rob_pkg::xdata_t          rf_read_data
);

    import rob_pkg::*;

    xdata_t rf [`NUM_ARCH_REGS];
    logic   rf_we;

    // branch resolved differently than predicted
    assign flush = head_valid && head.disp.is_branch &&
                   (head.disp.predicted_taken != head.actual_taken);

    // x0 never written, decoder already masks rd == 0
    assign rf_we = head_valid && head.disp.writes_rd && (head.disp.rd != '0);

    // x0 hardwired to zero on the read side too
    assign rf_read_data = (rf_read_addr == '0) ? '0 : rf[rf_read_addr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we) begin
            rf[head.disp.rd] <= head.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid   <= 1'b0;
            store_valid    <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            retire_valid   <= head_valid;
            store_valid    <= head_valid && head.disp.is_store;
            redirect_valid <= flush;
        end
    end

    // report payload, qualified by the valids above
    always_ff @(posedge clk) begin
        if (head_valid) begin
            retire.tag       <= head.tag;
            retire.rd        <= head.disp.rd;
            retire.data      <= head.data;
            retire.wrote_rd  <= rf_we;
            retire.was_store <= head.disp.is_store;
            store_tag        <= head.tag;
        end
        if (flush) begin
            redirect_pc <= head.target;
        end
    end

endmodule

/* logic/reorder_buffer.sv */
`timescale 1ns/100ps
`include "rob_defines.svh"

module reorder_buffer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                disp_valid,
    input  rob_pkg::dispatch_t  disp,
    input  logic                complete_valid,
    input  rob_pkg::complete_t  complete,
    input  logic                flush,
    output logic                tag_valid,
    output rob_pkg::tag_t       tag_out,
    output logic                full,
    output logic                head_valid,
    output rob_pkg::retire_t    head
);

    import rob_pkg::*;

    // per-slot status
    logic [`ROB_DEPTH-1:0] occupied;
    logic [`ROB_DEPTH-1:0] done;

    // per-slot payload
    dispatch_t disp_mem   [`ROB_DEPTH];
    xdata_t    data_mem   [`ROB_DEPTH];
    logic      taken_mem  [`ROB_DEPTH];
    pc_t       target_mem [`ROB_DEPTH];

    tag_t           rd_ptr;
    tag_t           wr_ptr;
    logic [`TAG_W:0] count;

    logic alloc;
    logic comp_hit;

    // issuing while full is ignored here
    assign alloc = disp_valid && !full;

    // stale completions to free slots are dropped
    assign comp_hit = complete_valid && occupied[complete.tag];

    assign full      = (count == `ROB_DEPTH);
    assign tag_valid = disp_valid;
    assign tag_out   = wr_ptr;

    // oldest entry goes out as soon as it is done
    assign head_valid = occupied[rd_ptr] && done[rd_ptr];

    always_comb begin
        head.tag          = rd_ptr;
        head.disp         = disp_mem[rd_ptr];
        head.data         = data_mem[rd_ptr];
        head.actual_taken = taken_mem[rd_ptr];
        head.target       = target_mem[rd_ptr];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occupied <= '0;
            done     <= '0;
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
        end else if (flush) begin
            // mispredict, drop everything in flight
            occupied <= '0;
            done     <= '0;
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
        end else begin
            if (comp_hit) begin
                done[complete.tag] <= 1'b1;
            end

            if (alloc) begin
                occupied[wr_ptr] <= 1'b1;
                done[wr_ptr]     <= 1'b0;
                wr_ptr           <= wr_ptr + 1'b1;
            end

            // release frees the head slot, pointer wraps naturally
            if (head_valid) begin
                occupied[rd_ptr] <= 1'b0;
                done[rd_ptr]     <= 1'b0;
                rd_ptr           <= rd_ptr + 1'b1;
            end

            case ({alloc, head_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload writes, slot validity comes from the flags above
    always_ff @(posedge clk) begin
        if (alloc) begin
            disp_mem[wr_ptr] <= disp;
        end
        if (comp_hit) begin
            data_mem[complete.tag]   <= complete.data;
            taken_mem[complete.tag]  <= complete.actual_taken;
            target_mem[complete.tag] <= complete.target;
        end
    end

endmodule

/* logic/dispatch_decoder.sv */
`timescale 1ns/100ps
`include "rob_defines.svh"

module dispatch_decoder (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                issue_valid,
    input  rob_pkg::issue_t     issue,
    input  logic                flush,
    output logic                disp_valid,
    output rob_pkg::dispatch_t  disp
);

    import rob_pkg::*;

    dispatch_t disp_d;
    logic      op_store;
    logic      op_branch;

    // opcode classification
    assign op_store  = (issue.opcode == `OP_STORE);
    assign op_branch = (issue.opcode == `OP_BRANCH);

    always_comb begin
        disp_d.is_store        = op_store;
        disp_d.is_branch       = op_branch;
        disp_d.rd              = issue.rd;
        disp_d.predicted_taken = issue.predicted_taken;
        // only plain ALU/load style ops with a real destination
        disp_d.writes_rd       = !op_store && !op_branch && (issue.rd != '0);
    end

    // valid bit, an issue during flush is dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            disp_valid <= 1'b0;
        end else begin
            disp_valid <= issue_valid && !flush;
        end
    end

    // decoded fields, captured on each issue
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            disp <= disp_d;
        end
    end

endmodule

/* logic/rob_pkg.sv */
`include "rob_defines.svh"

package rob_pkg;

    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [4:0]        reg_idx_t;
    typedef logic [`XLEN-1:0]  xdata_t;
    typedef logic [`PC_W-1:0]  pc_t;
    typedef logic [6:0]        opcode_t;

    // raw fields from the issue side
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        logic     predicted_taken;
    } issue_t;

    // decoded entry, decoder to buffer
    typedef struct packed {
        logic     is_store;
        logic     is_branch;
        logic     writes_rd;
        reg_idx_t rd;
        logic     predicted_taken;
    } dispatch_t;

    // result returned by an execution unit
    typedef struct packed {
        tag_t   tag;
        xdata_t data;
        logic   actual_taken;
        pc_t    target;
    } complete_t;

    // oldest entry handed to the commit stage
    typedef struct packed {
        tag_t      tag;
        dispatch_t disp;
        xdata_t    data;
        logic      actual_taken;
        pc_t       target;
    } retire_t;

    typedef struct packed {
        tag_t     tag;
        reg_idx_t rd;
        xdata_t   data;
        logic     wrote_rd;
        logic     was_store;
    } retire_report_t;

endpackage

/* logic/rob_defines.svh */
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// reorder buffer geometry
`define ROB_DEPTH 16
`define TAG_W     4

// datapath widths
`define XLEN      32
`define PC_W      32

// architectural register count, x0 included
`define NUM_ARCH_REGS 32

// major opcodes of interest, RV32I encoding
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011

`endif
